//--- filelist.f
verilog/snd_pkg.sv
verilog/cmd_sequencer.sv
verilog/reg_fifo.sv
verilog/tone_synth.sv
verilog/sound_board.sv
test/sound_checker.sv
test/tb_sound.sv

//--- run.sh
#!/usr/bin/env bash
# builds the sound board testbench with verilator and runs it
# exit status is 0 only when the run reports a pass
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_sound \
    -f filelist.f -o sim_sound

out="$(./obj_dir/sim_sound)"
echo "$out"

if grep -qF '** PASS **' <<< "$out"; then
    exit 0
fi
exit 1

//--- test/tb_sound.sv
//################################################
// testbench for the sound command board
// issues commands and models the sound rom with random wait
// states and hands each settled state to sound_checker
//################################################

`timescale 1ns/1ps

module tb_sound;

    localparam int SAMPLE_DIV   = 8;
    // worst case is each script byte at 3 wait states plus a tick to drain
    // then every compared sample plus one tick of alignment per test
    localparam int SCRIPT_BYTES = 1 + 9 + 11 + 16 + 7;
    localparam int WINDOWS      = 20 + 20 + 64 + 64 + 128 + 32 + 6;
    localparam int LIMIT_CYC    = SCRIPT_BYTES * (4 + SAMPLE_DIV) + WINDOWS * SAMPLE_DIV + 100;

    typedef struct packed {
        logic [15:0] inc;
        logic [3:0]  vol;
        logic [1:0]  pan;
    } chan_cfg_t;

    logic               clk;
    logic               rst;
    logic               snd_irq;
    snd_pkg::cmd_t      snd_latch;
    snd_pkg::rom_addr_t rom_addr;
    logic               rom_cs;
    snd_pkg::rom_data_t rom_data;
    logic               rom_ok;
    snd_pkg::sample_t   snd_left;
    snd_pkg::sample_t   snd_right;
    logic               sample;
    logic               busy;
    logic               check_req;
    int                 test_num;
    chan_cfg_t [3:0]    exp_cfg;       // register state the board should hold
    int                 tests_done;
    int                 fails;
    int                 tb_errors;     // checks outside the level windows
    int unsigned        lcg_state;
    snd_pkg::rom_data_t rom_mem [4096];

    sound_board #(.DEPTH(4), .SAMPLE_DIV(SAMPLE_DIV), .SCRIPT_LEN(16)) dut0 (
        .clk(clk), .rst(rst), .snd_irq(snd_irq), .snd_latch(snd_latch),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .snd_left(snd_left), .snd_right(snd_right), .sample(sample), .busy(busy)
    );

    sound_checker #(.SAMPLE_DIV(SAMPLE_DIV)) chk0 (
        .clk(clk), .snd_left(snd_left), .snd_right(snd_right), .sample(sample),
        .check_req(check_req), .test_num(test_num), .exp_cfg(exp_cfg),
        .tests_done(tests_done), .fails(fails)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    // 16 bytes at cmd*16 with index 0 first
    task automatic put_script(input snd_pkg::cmd_t c, input logic [0:15][7:0] bytes);
        for (int i = 0; i < 16; i++) begin
            rom_mem[{c, 4'(i)}] = bytes[i];
        end
    endtask

    task automatic set_chan(input int ch, input logic [15:0] inc, input logic [3:0] vol,
                            input logic [1:0] pan);
        exp_cfg[ch].inc = inc;
        exp_cfg[ch].vol = vol;
        exp_cfg[ch].pan = pan;
    endtask

    task automatic send_cmd(input snd_pkg::cmd_t c);
        @(negedge clk);
        snd_latch = c;
        snd_irq   = 1'b1;      // rising edge seen on the next clock
        @(negedge clk);
        snd_irq   = 1'b0;
    endtask

    // a rising edge on snd_irq every other clock for as long as busy is up
    task automatic pulse_while_busy(input snd_pkg::cmd_t c);
        snd_latch = c;
        while (busy) begin
            snd_irq = ~snd_irq;    // sampled with busy still high
            @(negedge clk);
        end
        snd_irq = 1'b0;
    endtask

    // busy up and then down after the last write is applied
    task automatic wait_idle();
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            tb_errors++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic request_window(input int num);
        @(negedge clk);
        test_num  = num;
        check_req = 1'b1;
        @(negedge clk);
        check_req = 1'b0;
        wait (tests_done == num);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 0 to 3 wait states per request with data valid in the rom_ok cycle
    initial begin : rom_model
        int waits;
        rom_ok   = 1'b0;
        rom_data = '0;
        forever begin
            @(negedge clk);
            rom_ok = 1'b0;
            if (rom_cs) begin
                waits = int'(lcg_next() % 4);
                repeat (waits) @(negedge clk);
                rom_data = rom_mem[rom_addr];   // address held while waiting
                rom_ok   = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout: run still going after %0d clock cycles", LIMIT_CYC);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        rst       = 1'b1;
        snd_irq   = 1'b0;
        snd_latch = '0;
        check_req = 1'b0;
        test_num  = 0;
        exp_cfg   = '0;
        tb_errors = 0;
        lcg_state = 16;
        for (int a = 0; a < 4096; a++) begin
            rom_mem[a] = snd_pkg::rom_data_t'(a[7:0] ^ a[11:4]);
        end
        put_script(8'h01, {16{8'hFF}});           // empty
        // ch0 inc 0x0400, vol 5, left
        put_script(8'h02, {8'h00, 8'h00, 8'h01, 8'h04, 8'h02, 8'h05, 8'h03, 8'h01,
                           {8{8'hFF}}});
        // ch0 to both sides, ch1 inc 0x0800 vol 3 right
        put_script(8'h03, {8'h03, 8'h03, 8'h04, 8'h00, 8'h05, 8'h08, 8'h06, 8'h03,
                           8'h07, 8'h02, {6{8'hFF}}});
        // full eight pairs ending by length
        put_script(8'h04, {8'h06, 8'h00, 8'h03, 8'h01, 8'h01, 8'h02, 8'h02, 8'h07,
                           8'h08, 8'h00, 8'h09, 8'h10, 8'h0A, 8'h02, 8'h0B, 8'h02});
        put_script(8'h05, {8'h0A, 8'h00, 8'h01, 8'h08, 8'h02, 8'h04, {10{8'hFF}}});
        // only played if the busy gate fails
        put_script(8'h06, {8'h02, 8'h0F, 8'h0D, 8'h04, 8'h0E, 8'h09, 8'h0F, 8'h03,
                           {8{8'hFF}}});
        repeat (2) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        expect_flag("busy", busy, 1'b0);
        expect_flag("rom_cs", rom_cs, 1'b0);
        request_window(1);

        send_cmd(8'h01);
        wait_idle();
        request_window(2);

        set_chan(0, 16'd1024, 4'd5, 2'b01);
        send_cmd(8'h02);
        wait_idle();
        request_window(3);

        set_chan(0, 16'd1024, 4'd5, 2'b11);
        set_chan(1, 16'd2048, 4'd3, 2'b10);
        send_cmd(8'h03);
        wait_idle();
        request_window(4);

        set_chan(0, 16'd512, 4'd7, 2'b01);
        set_chan(1, 16'd2048, 4'd0, 2'b10);
        set_chan(2, 16'd4096, 4'd2, 2'b10);
        send_cmd(8'h04);            // fifo fills and ack is held off
        wait_idle();
        request_window(5);

        set_chan(0, 16'd2048, 4'd4, 2'b01);
        set_chan(2, 16'd4096, 4'd0, 2'b10);
        send_cmd(8'h05);
        expect_flag("busy", busy, 1'b1);
        pulse_while_busy(8'h06);    // edges through the rom fetch and the fifo drain
        request_window(6);

        $display("summary: %0d tests, %0d failed, %0d other errors",
                 tests_done, fails, tb_errors);
        if (fails == 0 && tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- test/sound_checker.sv
//################################################
// level checker for the sound board testbench
// on check_req it reads one window of samples and compares
// them with the levels the channel settings allow
// also checks the spacing of the sample strobe
// prints one line per test and keeps test and fail counts
//################################################

`timescale 1ns/1ps

module sound_checker #(
    parameter int SAMPLE_DIV = 8       // clocks between sample strobes
) (
    input  logic             clk,
    input  snd_pkg::sample_t snd_left,
    input  snd_pkg::sample_t snd_right,
    input  logic             sample,
    input  logic             check_req,   // start a window on this clock
    input  int               test_num,
    input  logic [87:0]      exp_cfg,     // four channel settings with ch0 lowest
    output int               tests_done,
    output int               fails
);

    typedef struct packed {
        logic [15:0] inc;
        logic [3:0]  vol;
        logic [1:0]  pan;        // bit 0 left, bit 1 right
    } chan_cfg_t;

    // one side for a sign pattern where combo bit ch marks channel ch negative
    function automatic int side_level(input chan_cfg_t [3:0] cfg, input int combo,
                                      input int side);
        int sum;
        int amp;
        sum = 0;
        for (int ch = 0; ch < 4; ch++) begin
            amp = int'(cfg[ch].vol) * 256;
            if (cfg[ch].pan[side]) sum += combo[ch] ? -amp : amp;
        end
        return sum;
    endfunction

    function automatic bit level_ok(input chan_cfg_t [3:0] cfg, input int side, input int v);
        bit hit;
        hit = 1'b0;
        for (int c = 0; c < 16; c++) begin
            if (side_level(cfg, c, side) == v) hit = 1'b1;
        end
        return hit;
    endfunction

    // distinct allowed levels for the error lines
    function automatic string level_text(input chan_cfg_t [3:0] cfg, input int side);
        string s;
        bit    seen;
        int    v;
        s = "";
        for (int c = 0; c < 16; c++) begin
            v    = side_level(cfg, c, side);
            seen = 1'b0;
            for (int d = 0; d < c; d++) begin
                if (side_level(cfg, d, side) == v) seen = 1'b1;
            end
            if (!seen) s = {s, $sformatf(" %0d", v)};
        end
        return s;
    endfunction

    // one period of the single audible left channel with half of it positive
    // increments are powers of two so the period is whole
    function automatic void left_expect(input chan_cfg_t [3:0] cfg, output int window,
                                        output int high);
        int n;
        int inc;
        n   = 0;
        inc = 0;
        for (int ch = 0; ch < 4; ch++) begin
            if (cfg[ch].pan[0] && cfg[ch].vol != 0) begin
                n++;
                inc = int'(cfg[ch].inc);
            end
        end
        window = 20;                       // silent left or mixed channels
        high   = (n == 0) ? 0 : -1;        // -1 skips the count compare
        if (n == 1 && inc != 0) begin
            window = 65536 / inc;
            high   = window / 2;
        end
    endfunction

    task automatic run_window();
        chan_cfg_t [3:0] cfg;
        int window;
        int high;
        int pos;
        int errs;
        int got_l;
        int got_r;
        int gap;
        cfg  = exp_cfg;
        pos  = 0;
        errs = 0;
        left_expect(cfg, window, high);
        for (int n = 0; n < window; n++) begin
            @(negedge clk);
            gap = 1;
            while (!sample) begin             // held since the last tick
                @(negedge clk);
                gap++;
            end
            if (n > 0 && gap != SAMPLE_DIV) begin
                errs++;
                $display("ERROR t=%0t sample period got %0d expected %0d",
                         $time, gap, SAMPLE_DIV);
            end
            got_l = int'(snd_left);
            got_r = int'(snd_right);
            if (got_l > 0) pos++;
            if (!level_ok(cfg, 0, got_l)) begin
                errs++;
                $display("ERROR t=%0t snd_left got %0d expected one of%s",
                         $time, got_l, level_text(cfg, 0));
            end
            if (!level_ok(cfg, 1, got_r)) begin
                errs++;
                $display("ERROR t=%0t snd_right got %0d expected one of%s",
                         $time, got_r, level_text(cfg, 1));
            end
        end
        if (high >= 0 && pos != high) begin
            errs++;
            $display("ERROR t=%0t snd_left positive samples got %0d expected %0d",
                     $time, pos, high);
        end
        $display("test %0d %s: %0d samples, %0d positive on left, %0d errors",
                 test_num, (errs == 0) ? "passed" : "failed", window, pos, errs);
        if (errs != 0) fails++;
        tests_done++;
    endtask

    initial begin
        tests_done = 0;
        fails      = 0;
        forever begin
            @(posedge clk);
            if (check_req) run_window();
        end
    end

endmodule

//--- verilog/sound_board.sv
//################################################
// sound command board top level
// the main cpu writes snd_latch and pulses snd_irq;
// the sequencer plays the rom script into the fifo and
// the tone synthesizer turns it into stereo samples
//################################################

`timescale 1ns/1ps

module sound_board #(
    parameter int DEPTH      = 4,    // fifo words
    parameter int SAMPLE_DIV = 64,   // clocks per sample
    parameter int SCRIPT_LEN = 16    // bytes per script
) (
    input  logic               clk,
    input  logic               rst,
    // main cpu
    input  logic               snd_irq,
    input  snd_pkg::cmd_t      snd_latch,
    // sound rom
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::rom_data_t rom_data,
    input  logic               rom_ok,
    // audio
    output snd_pkg::sample_t   snd_left,
    output snd_pkg::sample_t   snd_right,
    output logic               sample,
    output logic               busy
);

    snd_pkg::wb_req_t    wb_req;
    logic                wb_ack;
    logic                wr_valid;
    snd_pkg::reg_write_t wr_head;
    logic                wr_pop;
    logic                seq_idle;
    logic                fifo_empty;

    // falls only once the last write has left the fifo
    assign busy = !seq_idle || !fifo_empty;

    cmd_sequencer #(.SCRIPT_LEN(SCRIPT_LEN)) u_seq (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .snd_irq   ( snd_irq    ),
        .snd_latch ( snd_latch  ),
        .busy_in   ( busy       ),
        .rom_addr  ( rom_addr   ),
        .rom_cs    ( rom_cs     ),
        .rom_data  ( rom_data   ),
        .rom_ok    ( rom_ok     ),
        .wb_req    ( wb_req     ),
        .wb_ack    ( wb_ack     ),
        .idle      ( seq_idle   )
    );

    reg_fifo #(.DEPTH(DEPTH)) u_fifo (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .wb_req    ( wb_req     ),
        .wb_ack    ( wb_ack     ),  // back-pressure when full
        .wr_valid  ( wr_valid   ),
        .wr_head   ( wr_head    ),
        .wr_pop    ( wr_pop     ),
        .empty     ( fifo_empty )
    );

    tone_synth #(.SAMPLE_DIV(SAMPLE_DIV)) u_synth (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .wr_valid  ( wr_valid   ),
        .wr_head   ( wr_head    ),
        .wr_pop    ( wr_pop     ),  // only on a sample tick
        .snd_left  ( snd_left   ),
        .snd_right ( snd_right  ),
        .sample    ( sample     )
    );

endmodule

//--- verilog/tone_synth.sv
//################################################
// four channel square wave synthesizer
// a divider gives one sample tick every SAMPLE_DIV clocks;
// each tick takes at most one register write from the
// fifo, then sums the channel levels into left and right
//################################################

`timescale 1ns/1ps

module tone_synth #(
    parameter int SAMPLE_DIV = 64      // clocks per sample, at least 2
) (
    input  logic                clk,
    input  logic                rst,
    // register write port
    input  logic                wr_valid,
    input  snd_pkg::reg_write_t wr_head,
    output logic                wr_pop,
    // audio
    output snd_pkg::sample_t    snd_left,
    output snd_pkg::sample_t    snd_right,
    output logic                sample
);

    localparam int NCH = 4;
    localparam int DW  = $clog2(SAMPLE_DIV);

    // register fields, addr[1:0]
    localparam logic [1:0] FLD_FREQ_LO = 2'd0;
    localparam logic [1:0] FLD_FREQ_HI = 2'd1;  // also key-on
    localparam logic [1:0] FLD_VOL     = 2'd2;
    localparam logic [1:0] FLD_PAN     = 2'd3;

    typedef logic [15:0] phase_t;     // accumulator and increment
    typedef logic [3:0]  vol_t;
    typedef logic [1:0]  pan_t;       // bit 0 left, bit 1 right

    logic [DW-1:0]    div;
    logic             tick;
    phase_t           freq      [NCH];
    vol_t             vol       [NCH];
    pan_t             pan       [NCH];
    phase_t           phase     [NCH];
    phase_t           freq_nx   [NCH];
    vol_t             vol_nx    [NCH];
    pan_t             pan_nx    [NCH];
    phase_t           phase_cur [NCH];   // phase after any key-on
    snd_pkg::sample_t level     [NCH];
    snd_pkg::sample_t left_nx;
    snd_pkg::sample_t right_nx;

    // free running from reset release
    always_ff @(posedge clk) begin
        if (rst) begin
            div <= '0;
        end else begin
            div <= (div == DW'(SAMPLE_DIV - 1)) ? '0 : div + 1'b1;
        end
    end

    assign tick   = (div == DW'(SAMPLE_DIV - 1));
    assign sample = tick;               // same cycle as the tick
    assign wr_pop = tick & wr_valid;    // one write per sample

    // write applied first, the tick's output sees the new values
    always_comb begin
        left_nx  = '0;
        right_nx = '0;
        for (int ch = 0; ch < NCH; ch++) begin
            freq_nx[ch]   = freq[ch];
            vol_nx[ch]    = vol[ch];
            pan_nx[ch]    = pan[ch];
            phase_cur[ch] = phase[ch];
            if (wr_pop && wr_head.addr[3:2] == 2'(ch)) begin
                case (wr_head.addr[1:0])
                    FLD_FREQ_LO: freq_nx[ch][7:0] = wr_head.data;
                    FLD_FREQ_HI: begin
                        freq_nx[ch][15:8] = wr_head.data;
                        phase_cur[ch]     = '0;     // key-on restarts the wave
                    end
                    FLD_VOL: vol_nx[ch] = wr_head.data[3:0];
                    FLD_PAN: pan_nx[ch] = wr_head.data[1:0];
                    default: ;
                endcase
            end
            // +vol*256 in the first half period, -vol*256 in the second
            level[ch] = snd_pkg::sample_t'({4'd0, vol_nx[ch], 8'd0});
            if (phase_cur[ch][15]) begin
                level[ch] = -level[ch];
            end
            if (pan_nx[ch][0]) left_nx  = left_nx + level[ch];
            if (pan_nx[ch][1]) right_nx = right_nx + level[ch];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int ch = 0; ch < NCH; ch++) begin
                freq[ch]  <= '0;
                vol[ch]   <= '0;       // all muted
                pan[ch]   <= '0;
                phase[ch] <= '0;
            end
            snd_left  <= '0;
            snd_right <= '0;
        end else if (tick) begin
            for (int ch = 0; ch < NCH; ch++) begin
                freq[ch]  <= freq_nx[ch];
                vol[ch]   <= vol_nx[ch];
                pan[ch]   <= pan_nx[ch];
                phase[ch] <= phase_cur[ch] + freq_nx[ch]; // wraps mod 2^16
            end
            snd_left  <= left_nx;      // held until next tick
            snd_right <= right_nx;
        end
    end

endmodule

//--- verilog/reg_fifo.sv
//################################################
// register write fifo
// wishbone classic slave on the write side, ack is
// withheld while full; read side is a valid/pop pair
// feeding the synthesizer one word per sample tick
//################################################

`timescale 1ns/1ps

module reg_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    // wishbone write slave
    input  snd_pkg::wb_req_t    wb_req,
    output logic                wb_ack,
    // read side
    output logic                wr_valid,
    output snd_pkg::reg_write_t wr_head,
    input  logic                wr_pop,
    output logic                empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
    localparam int CW = $clog2(DEPTH + 1);                // count width

    snd_pkg::reg_write_t mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          push;
    logic          pop;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign wr_valid = !empty;
    assign wr_head  = mem[rd_ptr];

    // ack only with a free slot, no look-through on a same-cycle pop
    assign wb_ack = wb_req.cyc & wb_req.stb & wb_req.we & !full;
    assign push   = wb_ack;             // stored in the ack cycle
    assign pop    = wr_pop & !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= '{addr: wb_req.adr, data: wb_req.dat};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

endmodule

//--- verilog/cmd_sequencer.sv
//################################################
// command sequencer, stands in for the sound cpu
// a rising snd_irq latches the command byte, then the
// register-write script at command*16 is read from the
// sound rom and each pair is posted as a wishbone write
//################################################

`timescale 1ns/1ps

module cmd_sequencer #(
    parameter int SCRIPT_LEN = 16      // max bytes per script, even, up to 16
) (
    input  logic               clk,
    input  logic               rst,
    // main cpu
    input  logic               snd_irq,
    input  snd_pkg::cmd_t      snd_latch,
    input  logic               busy_in,    // board busy, new commands ignored
    // sound rom
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::rom_data_t rom_data,
    input  logic               rom_ok,
    // wishbone write master
    output snd_pkg::wb_req_t   wb_req,
    input  logic               wb_ack,
    output logic               idle
);

    snd_pkg::seq_state_t state;
    snd_pkg::cmd_t       cmd;       // latched command
    logic [3:0]          idx;       // byte index inside the script
    logic                last;      // current pair is the final one
    logic                irq_last;  // snd_irq one cycle ago
    logic                irq_rise;
    snd_pkg::reg_write_t pend;      // write waiting for ack

    assign irq_rise = snd_irq & ~irq_last;

    // rom request stays up through both fetch states
    // the address only moves on the rom_ok cycle
    assign rom_cs   = (state == snd_pkg::fetch_addr) || (state == snd_pkg::fetch_data);
    assign rom_addr = snd_pkg::rom_addr_t'({cmd, idx});
    assign idle     = (state == snd_pkg::idle);

    always_comb begin
        wb_req     = '0;
        wb_req.adr = pend.addr;
        wb_req.dat = pend.data;
        if (state == snd_pkg::post) begin // held until ack, drops the cycle after
            wb_req.cyc = 1'b1;
            wb_req.stb = 1'b1;
            wb_req.we  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= snd_pkg::idle;
            cmd      <= '0;
            idx      <= '0;
            last     <= 1'b0;
            irq_last <= 1'b0;
            pend     <= '0;
        end else begin
            irq_last <= snd_irq;
            case (state)
                snd_pkg::idle: begin
                    if (irq_rise && !busy_in) begin // edge while busy is dropped
                        cmd   <= snd_latch;
                        idx   <= '0;
                        last  <= 1'b0;
                        state <= snd_pkg::fetch_addr;
                    end
                end
                snd_pkg::fetch_addr: begin
                    if (rom_ok) begin
                        if (rom_data == snd_pkg::SCRIPT_END) begin
                            state <= snd_pkg::idle;    // end marker
                        end else begin
                            pend.addr <= rom_data[3:0]; // register in low nibble
                            idx       <= idx + 4'd1;
                            state     <= snd_pkg::fetch_data;
                        end
                    end
                end
                snd_pkg::fetch_data: begin
                    if (rom_ok) begin
                        pend.data <= rom_data;
                        last      <= (idx == 4'(SCRIPT_LEN - 1)); // script length reached
                        idx       <= idx + 4'd1;
                        state     <= snd_pkg::post;
                    end
                end
                snd_pkg::post: begin
                    if (wb_ack) begin
                        // fifo holds the word now
                        state <= last ? snd_pkg::idle : snd_pkg::fetch_addr;
                    end
                end
                default: state <= snd_pkg::idle;
            endcase
        end
    end

endmodule

//--- verilog/snd_pkg.sv
//################################################
// shared types for the sound command board
// bus items, register fields, audio samples and the sequencer states
// modules refer to these by scoped name, snd_pkg::name
//################################################

package snd_pkg;

    // main cpu side
    typedef logic [7:0]  cmd_t;         // command byte from snd_latch

    // sound rom, address is {command, script index}
    typedef logic [11:0] rom_addr_t;
    typedef logic [7:0]  rom_data_t;

    // synthesizer register file
    // addr[3:2] channel, addr[1:0] field
    // field 0 freq low, 1 freq high + key-on, 2 volume, 3 pan
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;

    // one register write, moves from sequencer through the fifo
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // wishbone classic master request, write only link
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        reg_data_t dat;
    } wb_req_t;

    typedef logic signed [15:0] sample_t;  // signed audio out

    localparam rom_data_t SCRIPT_END = 8'hFF;  // address byte that ends a script

    // sequencer fsm
    typedef enum logic [1:0] {
        idle,
        fetch_addr,
        fetch_data,
        post
    } seq_state_t;

endpackage
